/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbMemSystem
OBJDIR    ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

/* bankMemPkg.sv */
package bankMemPkg;

    localparam int NumBanks    = 4;       // Bank chosen by address bits 2:1
    localparam int MemWords    = 32768;   // Whole memory, split evenly over the banks
    localparam int MemAddrBits = 16;

    // Accepting edge to data on memRdData
    localparam int ReadLatency = 2;

endpackage

/* cacheCtrl.sv */
module cacheCtrl (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic [15:0]                        Addr,
    input  logic [15:0]                        DataIn,
    input  logic                               Rd,
    input  logic                               Wr,
    output logic [15:0]                        DataOut,
    output logic                               Done,
    output logic                               Stall,
    output logic                               CacheHit,
    cacheWayIf.ctrl                            way0,
    cacheWayIf.ctrl                            way1,
    output logic [bankMemPkg::MemAddrBits-1:0] memAddr,
    output logic [15:0]                        memWrData,
    output logic                               memRd,
    output logic                               memWr,
    input  logic [15:0]                        memRdData,
    input  logic [bankMemPkg::NumBanks-1:0]    bankBusy
);
    import cachePkg::*;
    import bankMemPkg::*;

    localparam int FillBits = $clog2(WordsPerLine);

    ctrlState_e          state;
    ctrlState_e          stateNext;
    logic [FillBits-1:0] fillBank;      // Next bank to fetch
    logic [FillBits-1:0] prevBank;
    logic                readFetched;   // Line came from memory in this request
    logic                victim;
    logic                fillWay;
    logic                fillChoice;
    logic                hit0;
    logic                hit1;
    logic                hitAny;
    logic                reqBusy;
    logic                fillBusy;
    logic                isCmp;
    logic                isAlloc;
    logic                wr0;
    logic                wr1;

    assign hit0   = way0.hit & way0.valid;
    assign hit1   = way1.hit & way1.valid;
    assign hitAny = hit0 | hit1;

    assign reqBusy  = bankBusy[Addr[2:1]];
    assign fillBusy = bankBusy[fillBank];
    assign isCmp    = (state == CompareTag);
    assign isAlloc  = (state == Allocate);
    assign prevBank = fillBank - 1'b1;  // Counter already moved on in ReadC1

    // Invalid way first, victim bit only when both are valid
    assign fillChoice = !way0.valid ? 1'b0 : (!way1.valid ? 1'b1 : victim);

    always_comb begin
        stateNext = state;
        unique case (state)
            WaitReq:    if ((Rd || Wr) && !Done) stateNext = CompareTag;
            CompareTag: begin
                if (Wr) begin
                    stateNext = Write;
                end else if (Rd && !hitAny) begin
                    stateNext = Read;
                end else begin
                    stateNext = WaitReq;
                end
            end
            Read:       if (!fillBusy) stateNext = ReadC1;
            ReadC1:     stateNext = Allocate;
            Allocate:   stateNext = (fillBank == '0) ? CompareTag : Read;
            Write:      if (!reqBusy) stateNext = WaitReq;
            default:    stateNext = WaitReq;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= WaitReq;
            fillBank    <= '0;
            readFetched <= 1'b0;
            victim      <= 1'b0;
            fillWay     <= 1'b0;
            Done        <= 1'b0;
        end else begin
            state <= stateNext;
            Done  <= (isCmp && Rd && !Wr && hitAny) || (state == Write && !reqBusy);
            if (state == ReadC1) begin
                fillBank <= fillBank + 1'b1;
            end
            if (isAlloc && fillBank == '0) begin
                readFetched <= 1'b1;
            end else if (state == WaitReq) begin
                readFetched <= 1'b0;
            end
            // Toggles on compare reads and any cache write
            victim <= victim ^ ((isCmp && Rd) || wr0 || wr1);
            if (isCmp && Rd && !Wr && !hitAny) begin
                fillWay <= fillChoice;
            end
        end
    end

    // Write hits store in compare mode, fills go to the latched way
    assign wr0 = (isAlloc && !fillWay) || (isCmp && Wr);
    assign wr1 = (isAlloc && fillWay) || (isCmp && Wr);

    assign way0.tag     = Addr[15 -: TagBits];
    assign way0.index   = Addr[OffsetBits +: IndexBits];
    assign way0.offset  = isAlloc ? {prevBank, 1'b0} : Addr[OffsetBits-1:0];
    assign way0.wrData  = isCmp ? DataIn : memRdData;
    assign way0.comp    = isCmp;
    assign way0.write   = wr0;
    assign way0.validIn = isAlloc && !fillWay;

    assign way1.tag     = Addr[15 -: TagBits];
    assign way1.index   = Addr[OffsetBits +: IndexBits];
    assign way1.offset  = isAlloc ? {prevBank, 1'b0} : Addr[OffsetBits-1:0];
    assign way1.wrData  = isCmp ? DataIn : memRdData;
    assign way1.comp    = isCmp;
    assign way1.write   = wr1;
    assign way1.validIn = isAlloc && fillWay;

    assign memRd     = (state == Read) && !fillBusy;
    assign memWr     = (state == Write) && !reqBusy;
    assign memAddr   = (state == Write) ? Addr : {Addr[15:3], fillBank, 1'b0};
    assign memWrData = DataIn;

    assign DataOut  = hit1 ? way1.dataOut : way0.dataOut;
    assign Stall    = (state != WaitReq) || Done;   // Also blocks the held request
    assign CacheHit = Done && Rd && hitAny && !readFetched;

    rdWrExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(memRd && memWr))
        else $error("memRd and memWr together");

    doneInIdle: assert property (@(posedge clk) disable iff (!rstN)
        Done |-> state == WaitReq)
        else $error("Done outside WaitReq");

    legalState: assert property (@(posedge clk) disable iff (!rstN)
        state inside {WaitReq, CompareTag, Read, ReadC1, Allocate, Write})
        else $error("illegal state %0d", state);

endmodule

/* cachePkg.sv */
package cachePkg;

    // Address split is tag | index | byte offset
    localparam int TagBits      = 5;    // Addr[15:11]
    localparam int IndexBits    = 8;    // Addr[10:3], 256 sets
    localparam int OffsetBits   = 3;    // Byte offset within a line
    localparam int WordsPerLine = 4;

    // Miss handling steps of the controller
    typedef enum logic [2:0] {
        WaitReq    = 3'd0,
        Read       = 3'd1,  // Issue fill read to one bank
        ReadC1     = 3'd2,
        Allocate   = 3'd3,  // Fill word lands in the victim way
        Write      = 3'd4,  // Write-through to memory
        CompareTag = 3'd5
    } ctrlState_e;

endpackage

/* cacheWay.sv */
module cacheWay (
    input  logic   clk,
    input  logic   rstN,
    cacheWayIf.way bus
);
    import cachePkg::*;

    localparam int NumSets  = 2 ** IndexBits;
    localparam int WordBits = $clog2(WordsPerLine);

    logic [TagBits-1:0]            tagMem  [NumSets];
    logic [15:0]                   dataMem [NumSets * WordsPerLine];
    logic [NumSets-1:0]            validQ;
    logic [IndexBits+WordBits-1:0] wordAddr;
    logic                          tagMatch;
    logic                          store;

    // Word within the line, byte bit dropped
    assign wordAddr = {bus.index, bus.offset[OffsetBits-1:1]};

    assign tagMatch    = (tagMem[bus.index] == bus.tag);
    assign bus.hit     = tagMatch;
    assign bus.valid   = validQ[bus.index];
    assign bus.dataOut = dataMem[wordAddr];

    // Compare mode needs a valid hit, fill mode always stores
    assign store = bus.write && (!bus.comp || (tagMatch && validQ[bus.index]));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= '0;
        end else if (store && !bus.comp) begin
            validQ[bus.index] <= bus.validIn;
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            dataMem[wordAddr] <= bus.wrData;
        end
        if (store && !bus.comp) begin
            tagMem[bus.index] <= bus.tag;   // Fill reloads the tag
        end
    end

    // Valid bits only change during a fill
    fillOnlySetsValid: assert property (@(posedge clk) disable iff (!rstN)
        bus.validIn |-> !bus.comp)
        else $error("validIn raised in compare mode");

endmodule

/* cacheWayIf.sv */
interface cacheWayIf;
    import cachePkg::*;

    // Request side
    logic [TagBits-1:0]    tag;
    logic [IndexBits-1:0]  index;
    logic [OffsetBits-1:0] offset;
    logic [15:0]           wrData;
    logic                  comp;      // Compare mode, store only on a valid hit
    logic                  write;
    logic                  validIn;

    // Lookup results, same cycle
    logic [15:0]           dataOut;
    logic                  hit;       // Tag equal, valid not included
    logic                  valid;

    modport ctrl (
        output tag,
        output index,
        output offset,
        output wrData,
        output comp,
        output write,
        output validIn,
        input  dataOut,
        input  hit,
        input  valid
    );

    modport way (
        input  tag,
        input  index,
        input  offset,
        input  wrData,
        input  comp,
        input  write,
        input  validIn,
        output dataOut,
        output hit,
        output valid
    );

endinterface

/* fourBankMem.sv */
module fourBankMem #(
    parameter int BankBusyCycles = 4
) (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic [bankMemPkg::MemAddrBits-1:0] memAddr,
    input  logic [15:0]                        memWrData,
    input  logic                               memRd,
    input  logic                               memWr,
    output logic [15:0]                        memRdData,
    output logic [bankMemPkg::NumBanks-1:0]    bankBusy
);
    import bankMemPkg::*;

    localparam int BankDepth = MemWords / NumBanks;
    localparam int BankBits  = $clog2(NumBanks);
    localparam int RowBits   = $clog2(BankDepth);
    localparam int CntBits   = $clog2(BankBusyCycles + 1);

    logic [BankBits-1:0] bankSel;
    logic [RowBits-1:0]  row;
    logic [BankBits-1:0] rdBankQ;                  // Bank of the read in stage 1
    logic [15:0]         bankQ  [NumBanks];
    logic [15:0]         rdPipe [ReadLatency-1];

    assign bankSel = memAddr[BankBits:1];          // Word interleave
    assign row     = memAddr[MemAddrBits-1 -: RowBits];

    for (genvar b = 0; b < NumBanks; b++) begin : gBank
        logic [15:0]        store [BankDepth];
        logic [15:0]        rdWord;
        logic [CntBits-1:0] busyCnt;
        logic               access;

        assign access      = (memRd || memWr) && (bankSel == BankBits'(b));
        assign bankBusy[b] = (busyCnt != '0);
        assign bankQ[b]    = rdWord;

        // Reload on each access, then count down to free
        always_ff @(posedge clk or negedge rstN) begin
            if (!rstN) begin
                busyCnt <= '0;
            end else if (access) begin
                busyCnt <= CntBits'(BankBusyCycles);
            end else if (busyCnt != '0) begin
                busyCnt <= busyCnt - 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (access && memWr) begin
                store[row] <= memWrData;
            end
            if (access && memRd) begin
                rdWord <= store[row];              // Stage 1
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdBankQ <= '0;
        end else if (memRd) begin
            rdBankQ <= bankSel;
        end
    end

    // Remaining stages, a new read may enter every cycle
    always_ff @(posedge clk) begin
        rdPipe[0] <= bankQ[rdBankQ];
        for (int i = 1; i < ReadLatency - 1; i++) begin
            rdPipe[i] <= rdPipe[i - 1];
        end
    end

    assign memRdData = rdPipe[ReadLatency-2];

    noBusyAccess: assert property (@(posedge clk) disable iff (!rstN)
        (memRd || memWr) |-> !bankBusy[bankSel])
        else $error("access to busy bank %0d", bankSel);

endmodule

/* memSystem.sv */
module memSystem #(
    parameter int BankBusyCycles = 4
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic [15:0] Addr,
    input  logic [15:0] DataIn,
    input  logic        Rd,
    input  logic        Wr,
    output logic [15:0] DataOut,
    output logic        Done,
    output logic        Stall,
    output logic        CacheHit
);
    import bankMemPkg::*;

    logic [MemAddrBits-1:0] memAddr;
    logic [15:0]            memWrData;
    logic [15:0]            memRdData;
    logic                   memRd;
    logic                   memWr;
    logic [NumBanks-1:0]    bankBusy;

    cacheWayIf way0Bus ();
    cacheWayIf way1Bus ();

    cacheCtrl ctrl (
        .clk       (clk),
        .rstN      (rstN),
        .Addr      (Addr),
        .DataIn    (DataIn),
        .Rd        (Rd),
        .Wr        (Wr),
        .DataOut   (DataOut),
        .Done      (Done),
        .Stall     (Stall),
        .CacheHit  (CacheHit),
        .way0      (way0Bus),
        .way1      (way1Bus),
        .memAddr   (memAddr),
        .memWrData (memWrData),
        .memRd     (memRd),
        .memWr     (memWr),
        .memRdData (memRdData),
        .bankBusy  (bankBusy)
    );

    cacheWay way0 (
        .clk  (clk),
        .rstN (rstN),
        .bus  (way0Bus)
    );

    cacheWay way1 (
        .clk  (clk),
        .rstN (rstN),
        .bus  (way1Bus)
    );

    fourBankMem #(
        .BankBusyCycles (BankBusyCycles)
    ) mem (
        .clk       (clk),
        .rstN      (rstN),
        .memAddr   (memAddr),
        .memWrData (memWrData),
        .memRd     (memRd),
        .memWr     (memWr),
        .memRdData (memRdData),
        .bankBusy  (bankBusy)
    );

endmodule

/* tbMemSystem.sv */
module tbMemSystem;
    import cachePkg::*;

    localparam int BusyCycles   = 5;
    localparam int DoneTimeout  = 200;
    localparam int StallTimeout = 10;

    logic        clk = 1'b0;
    logic        rstN;
    logic [15:0] Addr;
    logic [15:0] DataIn;
    logic        Rd;
    logic        Wr;
    logic [15:0] DataOut;
    logic        Done;
    logic        Stall;
    logic        CacheHit;

    // Reference model state
    logic [15:0]        shadow [logic [15:0]];      // Word by byte address
    logic [TagBits-1:0] modelTag   [2][2**IndexBits];
    bit                 modelValid [2][2**IndexBits];
    bit                 modelVictim;
    logic [16:0]        expQ [$];                   // {hit, data} per read

    logic [31:0] lcgState = 32'hb4cfe350;
    string       testName = "reset";
    int          reqCount;
    int          doneCount;
    bit          donePrev;

    memSystem #(.BankBusyCycles(BusyCycles)) dut_i (
        .clk      (clk),
        .rstN     (rstN),
        .Addr     (Addr),
        .DataIn   (DataIn),
        .Rd       (Rd),
        .Wr       (Wr),
        .DataOut  (DataOut),
        .Done     (Done),
        .Stall    (Stall),
        .CacheHit (CacheHit)
    );

    always #4 clk = ~clk;

    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [15:0] makeAddr(input int tag, input int index, input int word);
        return {TagBits'(tag), IndexBits'(index), 2'(word), 1'b0};
    endfunction

    // Expected {CacheHit, DataOut} of one request and the model update it causes
    function automatic logic [16:0] refAccess(input bit isWrite, input logic [15:0] addr,
                                              input logic [15:0] data);
        logic [TagBits-1:0]   tag;
        logic [IndexBits-1:0] idx;
        int                   way;
        tag = addr[15 -: TagBits];
        idx = addr[10:3];
        way = -1;
        for (int w = 0; w < 2; w++) begin
            if (modelValid[w][idx] && modelTag[w][idx] == tag) way = w;
        end
        if (isWrite) begin
            shadow[addr] = data;        // Memory always current and a hit copy follows
            modelVictim ^= 1'b1;        // One compare pass
            return {1'b0, data};
        end
        if (way >= 0) begin
            modelVictim ^= 1'b1;
            return {1'b1, shadow[addr]};
        end
        way = !modelValid[0][idx] ? 0 : (!modelValid[1][idx] ? 1 : int'(modelVictim));
        modelTag[way][idx]   = tag;
        modelValid[way][idx] = 1'b1;
        // Two compare passes plus one toggle per filled word
        repeat (2 + WordsPerLine) modelVictim ^= 1'b1;
        return {1'b0, shadow[addr]};
    endfunction

    task automatic runRequest(input bit isWrite, input logic [15:0] addr,
                              input logic [15:0] data, output logic hitSeen);
        int cycles;
        if (isWrite) void'(refAccess(1'b1, addr, data));
        else expQ.push_back(refAccess(1'b0, addr, data));
        @(posedge clk);
        Addr   <= addr;
        DataIn <= data;
        Rd     <= !isWrite;
        Wr     <= isWrite;
        reqCount++;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!Stall && cycles < StallTimeout);
        if (!Stall) stopWithFailure($sformatf("Stall never rose for request to %h", addr));
        cycles = 0;
        while (!Done && cycles < DoneTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!Done) stopWithFailure($sformatf("Timed out waiting for Done at %h", addr));
        hitSeen = CacheHit;
        @(posedge clk);
        Rd <= 1'b0;
        Wr <= 1'b0;
    endtask

    task automatic writeWord(input logic [15:0] addr, input logic [15:0] data);
        logic hitSeen;
        runRequest(1'b1, addr, data, hitSeen);
    endtask

    task automatic readWord(input logic [15:0] addr);
        logic hitSeen;
        runRequest(1'b0, addr, 16'h0000, hitSeen);
    endtask

    // Compares every finished read with the model and counts Done pulses
    always @(negedge clk) begin
        logic [16:0] expected;
        if (rstN) begin
            assert (!(Done && donePrev)) else stopWithFailure("Done stayed high two cycles");
            donePrev = Done;
            if (Done) doneCount++;
            if (Done && Rd) begin
                assert (expQ.size() > 0) else stopWithFailure("Read finished with nothing expected");
                expected = expQ.pop_front();
                assert (DataOut === expected[15:0]) else stopWithFailure($sformatf(
                    "CHECK FAILED %s DataOut at %h: expected %h, actual %h",
                    testName, Addr, expected[15:0], DataOut));
                assert (CacheHit === expected[16]) else stopWithFailure($sformatf(
                    "CHECK FAILED %s CacheHit at %h: expected %b, actual %b",
                    testName, Addr, expected[16], CacheHit));
            end
        end
    end

    initial begin
        logic        hitSeen;
        logic [31:0] r;
        logic [15:0] addr;
        int          order [8];
        order  = '{1, 2, 1, 3, 2, 1, 3, 3};
        rstN   <= 1'b0;
        Addr   <= 16'h0000;
        DataIn <= 16'h0000;
        Rd     <= 1'b0;
        Wr     <= 1'b0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        testName = "idleAfterReset";
        assert (!Done && !Stall) else stopWithFailure("Done or Stall high after reset");

        testName = "writeThenRead";
        writeWord(makeAddr(3, 17, 1), 16'hbeef);
        runRequest(1'b0, makeAddr(3, 17, 1), 16'h0000, hitSeen);
        assert (hitSeen === 1'b0) else stopWithFailure($sformatf(
            "CHECK FAILED %s first read hit: expected 0, actual %b", testName, hitSeen));
        runRequest(1'b0, makeAddr(3, 17, 1), 16'h0000, hitSeen);
        assert (hitSeen === 1'b1) else stopWithFailure($sformatf(
            "CHECK FAILED %s second read hit: expected 1, actual %b", testName, hitSeen));

        testName = "writeHit";
        writeWord(makeAddr(3, 17, 2), 16'h1234);   // Line already cached
        readWord(makeAddr(3, 17, 2));
        writeWord(makeAddr(3, 17, 1), 16'h5678);
        readWord(makeAddr(3, 17, 1));

        testName = "victimOrder";
        for (int t = 1; t <= 3; t++) writeWord(makeAddr(t, 40, 0), 16'h4000 + 16'(t));
        foreach (order[i]) readWord(makeAddr(order[i], 40, 0));

        testName = "randomMix";
        repeat (300) begin
            r    = nextRandom();
            addr = makeAddr(int'(r[29:28]) % 3, 7 + int'(r[27]), int'(r[25:24]));
            if (!shadow.exists(addr) || r[31]) writeWord(addr, r[23:8]);
            else readWord(addr);
        end

        testName = "sameBank";
        for (int k = 0; k < 6; k++) writeWord(makeAddr(k % 2, 90 + k, 2), 16'h6000 + 16'(k));
        for (int k = 0; k < 6; k++) readWord(makeAddr(k % 2, 90 + k, 2));
        for (int k = 0; k < 6; k++) begin
            writeWord(makeAddr(k % 2, 90 + k, 2), 16'h7000 + 16'(k));
            readWord(makeAddr(k % 2, 90 + k, 2));
        end

        testName = "doneCount";
        assert (doneCount == reqCount) else stopWithFailure($sformatf(
            "CHECK FAILED %s: expected %0d, actual %0d", testName, reqCount, doneCount));
        $display("** PASS **");
        $finish;
    end

endmodule

/* vlog.f */
cachePkg.sv
bankMemPkg.sv
cacheWayIf.sv
cacheWay.sv
fourBankMem.sv
cacheCtrl.sv
memSystem.sv
tbMemSystem.sv
